/* icache_pkg.sv */
package icache_pkg;

    localparam int LINE_WORDS  = 4;
    localparam int INDEX_BITS  = 6;
    localparam int NUM_LINES   = 64;
    localparam int TAG_BITS    = 22;
    localparam int OFFSET_BITS = $clog2(LINE_WORDS);  // word select inside one line

    localparam logic [31:0] RESET_PC = 32'h0000_0000;

    // controller state encodings
    localparam logic [1:0] ST_LOOKUP     = 2'd1;
    localparam logic [1:0] ST_MEM_READ   = 2'd2;
    localparam logic [1:0] ST_LINE_WRITE = 2'd3;

    typedef struct packed {
        logic [TAG_BITS-1:0]    tag;
        logic [INDEX_BITS-1:0]  index;
        logic [OFFSET_BITS-1:0] word;
        logic [1:0]             byte_off;
    } fetch_fields_t;

    // the fetch address is read either as a plain word or split into cache fields
    typedef union packed {
        logic [31:0]   raw;
        fetch_fields_t f;
    } fetch_addr_u;

    typedef logic [LINE_WORDS-1:0][31:0] cache_line_t;  // word 0 sits in the low bits

    typedef struct packed {
        logic        valid;  // one-cycle request pulse
        logic [31:0] addr;   // always line-aligned
    } mem_req_t;

    typedef struct packed {
        logic        ready;  // one-cycle strobe with the line
        cache_line_t line;
    } mem_rsp_t;

    typedef struct packed {
        logic        we;
        fetch_addr_u addr;
        cache_line_t line;
    } cache_fill_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] target;
    } redirect_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] instr;
    } fetch_out_t;

endpackage

/* fetch_pc.sv */
module fetch_pc
    import icache_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        stall_i,
    input  logic        deliver_i,
    input  redirect_t   redirect_i,
    output fetch_addr_u pc_o
);

    fetch_addr_u pc_q;
    fetch_addr_u pc_d;
    logic        advance;

    // the pc steps by one word only on a delivery that is not stalled
    assign advance = deliver_i && !stall_i;

    always_comb begin
        pc_d = pc_q;
        if (redirect_i.valid) begin
            pc_d.raw = redirect_i.target;  // a redirect wins over the advance
        end
        else if (advance) begin
            pc_d.raw = pc_q.raw + 32'd4;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            pc_q.raw <= RESET_PC;
        end
        else begin
            pc_q <= pc_d;
        end
    end

    assign pc_o = pc_q;

    // instructions are 32 bits, so the byte offset of the pc must stay zero
    a_pc_aligned: assert property (
        @(posedge clk_i) disable iff (!rst_i)
        pc_q.f.byte_off == 2'b00
    ) else $error("fetch_pc: pc 0x%08h is not word-aligned", pc_q.raw);

endmodule

/* icache_array.sv */
module icache_array
    import icache_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_i,
    input  fetch_addr_u pc_i,
    input  cache_fill_t fill_i,
    output logic        hit_o,
    output logic [31:0] word_o
);

    logic [TAG_BITS-1:0] tag_mem  [NUM_LINES];
    cache_line_t         data_mem [NUM_LINES];
    logic [NUM_LINES-1:0] valid_q;

    logic [INDEX_BITS-1:0] rd_index;
    logic [INDEX_BITS-1:0] wr_index;
    logic [TAG_BITS-1:0]   rd_tag;
    cache_line_t           rd_line;
    logic                  tag_match;

    assign rd_index = pc_i.f.index;
    assign wr_index = fill_i.addr.f.index;

    // lookup is purely combinational so a hit can be delivered in the same cycle
    assign rd_tag    = tag_mem[rd_index];
    assign rd_line   = data_mem[rd_index];
    assign tag_match = rd_tag == pc_i.f.tag;

    assign hit_o  = valid_q[rd_index] && tag_match;
    assign word_o = rd_line[pc_i.f.word];  // meaningless on a miss and ignored by the controller

    // reset invalidates every line
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            valid_q <= '0;
        end
        else if (fill_i.we) begin
            valid_q[wr_index] <= 1'b1;
        end
    end

    // the whole line and its tag are replaced in one write
    always_ff @(posedge clk_i) begin
        if (fill_i.we) begin
            tag_mem[wr_index]  <= fill_i.addr.f.tag;
            data_mem[wr_index] <= fill_i.line;
        end
    end

    // a fill always carries a full line, so its address has no word or byte offset
    a_fill_aligned: assert property (
        @(posedge clk_i) disable iff (!rst_i)
        fill_i.we |-> (fill_i.addr.f.word == '0 && fill_i.addr.f.byte_off == '0)
    ) else $error("icache_array: fill address 0x%08h is not line-aligned", fill_i.addr.raw);

endmodule

/* icache_controller.sv */
module icache_controller
    import icache_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        stall_i,
    input  fetch_addr_u pc_i,
    input  logic        hit_i,
    input  logic [31:0] hit_word_i,
    input  logic        mem_ready_i,
    input  mem_rsp_t    mem_rsp_i,
    output mem_req_t    mem_req_o,
    output cache_fill_t fill_o,
    output fetch_out_t  fetch_o,
    output logic        deliver_o
);

    logic [1:0]  state_q;
    logic [1:0]  state_d;
    fetch_addr_u miss_q;  // the whole missed pc for the later compare
    fetch_addr_u miss_d;
    cache_line_t line_q;  // copy of the returned line for the delivery cycle
    logic        capture_line;
    logic        pc_same;

    // clears the word and byte offsets to get the start of the line
    function automatic fetch_addr_u line_base(input fetch_addr_u addr);
        fetch_addr_u base;
        base            = addr;
        base.f.word     = '0;
        base.f.byte_off = '0;
        return base;
    endfunction

    assign pc_same      = pc_i.raw == miss_q.raw;
    assign capture_line = (state_q == ST_MEM_READ) && mem_rsp_i.ready;

    always_comb begin
        state_d   = state_q;
        miss_d    = miss_q;
        mem_req_o = '0;
        fill_o    = '0;
        fetch_o   = '0;

        case (state_q)
            ST_LOOKUP: begin
                // no fetch activity while reset is held
                if (rst_i && !stall_i) begin
                    if (hit_i) begin
                        fetch_o.valid = 1'b1;
                        fetch_o.pc    = pc_i.raw;
                        fetch_o.instr = hit_word_i;
                    end
                    else if (mem_ready_i) begin
                        mem_req_o.valid = 1'b1;  // a single pulse because the state moves on
                        mem_req_o.addr  = line_base(pc_i).raw;
                        miss_d          = pc_i;
                        state_d         = ST_MEM_READ;
                    end
                end
            end

            ST_MEM_READ: begin
                if (mem_rsp_i.ready) begin
                    fill_o.we   = 1'b1;
                    fill_o.addr = line_base(miss_q);
                    fill_o.line = mem_rsp_i.line;
                    // a stall here still keeps the line but skips delivery
                    state_d     = stall_i ? ST_LOOKUP : ST_LINE_WRITE;
                end
            end

            ST_LINE_WRITE: begin
                // the pc may have been redirected while memory was busy
                if (!stall_i && pc_same) begin
                    fetch_o.valid = 1'b1;
                    fetch_o.pc    = miss_q.raw;
                    fetch_o.instr = line_q[miss_q.f.word];
                end
                state_d = ST_LOOKUP;
            end

            default: begin
                state_d = ST_LOOKUP;
            end
        endcase
    end

    assign deliver_o = fetch_o.valid;  // tells the pc unit to step by one word

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state_q <= ST_LOOKUP;
        end
        else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        miss_q <= miss_d;
        if (capture_line) begin
            line_q <= mem_rsp_i.line;
        end
    end

    // requests leave only from lookup with memory ready, and the miss is then in flight
    a_req_from_lookup: assert property (
        @(posedge clk_i) disable iff (!rst_i)
        mem_req_o.valid |-> (state_q == ST_LOOKUP && mem_ready_i) ##1 (state_q == ST_MEM_READ)
    ) else $error("icache_controller: memory request outside lookup");

    // a line write and a delivery never share a cycle
    a_fill_or_fetch: assert property (
        @(posedge clk_i) disable iff (!rst_i)
        !(fetch_o.valid && fill_o.we)
    ) else $error("icache_controller: fetch valid during a line write");

endmodule

/* icache_fetch_top.sv */
module icache_fetch_top
    import icache_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_i,
    input  logic       stall_i,
    input  redirect_t  redirect_i,
    input  logic       mem_ready_i,
    input  mem_rsp_t   mem_rsp_i,
    output mem_req_t   mem_req_o,
    output fetch_out_t fetch_o
);

    fetch_addr_u pc;
    logic        hit;
    logic [31:0] hit_word;
    cache_fill_t fill;
    logic        deliver;

    fetch_pc u_fetch_pc (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .stall_i    (stall_i),
        .deliver_i  (deliver),
        .redirect_i (redirect_i),
        .pc_o       (pc)
    );

    // the same pc drives both the lookup and the controller
    icache_array u_icache_array (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .pc_i   (pc),
        .fill_i (fill),
        .hit_o  (hit),
        .word_o (hit_word)
    );

    icache_controller u_icache_controller (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .stall_i     (stall_i),
        .pc_i        (pc),
        .hit_i       (hit),
        .hit_word_i  (hit_word),
        .mem_ready_i (mem_ready_i),
        .mem_rsp_i   (mem_rsp_i),
        .mem_req_o   (mem_req_o),
        .fill_o      (fill),
        .fetch_o     (fetch_o),
        .deliver_o   (deliver)
    );

endmodule

/* tb_clock_gen.sv */
module tb_clock_gen (
    output logic clk_o,
    output logic rst_o
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int HALF_PERIOD  = 20;  // 40 ns clock period
    localparam int RESET_CYCLES = 4;

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD) clk_o = ~clk_o;
    end

    initial begin
        rst_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_o <= 1'b1;  // released on the fourth rising edge
    end

endmodule

/* tb_main_memory.sv */
module tb_main_memory
    import icache_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_i,
    input  mem_req_t mem_req_i,
    output logic     mem_ready_o,
    output mem_rsp_t mem_rsp_o,
    output int       req_count_o
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [31:0] lfsr;
    logic [31:0] line_addr;
    int          delay;

    // Fibonacci LFSR with taps 32, 22, 2 and 1 that shifts the new bit in at bit 0
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    // every word holds its own byte address XOR 32'hA5A5_0000
    function automatic cache_line_t line_words(input logic [31:0] base);
        cache_line_t line;
        for (int i = 0; i < LINE_WORDS; i++) begin
            line[i] = (base + 32'(4 * i)) ^ 32'hA5A5_0000;
        end
        return line;
    endfunction

    initial begin
        mem_ready_o = 1'b1;
        mem_rsp_o   = '0;
        req_count_o = 0;
        lfsr        = 32'h8609;
        line_addr   = '0;
        delay       = 0;
        forever begin
            @(posedge clk_i);
            if (!rst_i) begin
                mem_ready_o <= 1'b1;
                mem_rsp_o   <= '0;
                req_count_o <= 0;
                delay       = 0;
            end
            else begin
                mem_rsp_o.ready <= 1'b0;
                if (mem_req_i.valid) begin
                    req_count_o <= req_count_o + 1;
                end
                if (mem_rsp_o.ready) begin
                    mem_ready_o <= 1'b1;  // the line has gone out so the next request is taken
                end
                if (mem_req_i.valid && mem_ready_o) begin
                    // two LFSR bits of one step each give a delay of 2 to 5 cycles
                    lfsr      = lfsr_step(lfsr);
                    delay     = 2 * int'(lfsr[0]);
                    lfsr      = lfsr_step(lfsr);
                    delay     = delay + int'(lfsr[0]) + 2;
                    line_addr = mem_req_i.addr;
                    mem_ready_o <= 1'b0;
                end
                else if (delay > 0) begin
                    delay = delay - 1;
                    if (delay == 0) begin
                        mem_rsp_o.ready <= 1'b1;
                        mem_rsp_o.line  <= line_words(line_addr);
                    end
                end
            end
        end
    end

endmodule

/* tb_icache_fetch.sv */
module tb_icache_fetch
    import icache_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int WAIT_LIMIT = 300;  // cycles allowed for any single wait

    logic       clk;
    logic       rst;
    logic       stall;
    redirect_t  redirect;
    logic       mem_ready;
    mem_rsp_t   mem_rsp;
    mem_req_t   mem_req;
    fetch_out_t fetch;
    int         req_count;
    fetch_out_t fetch_q[$];
    mem_req_t   req_q[$];
    int         rsp_seen;
    int         value_errors;
    int         timeouts;

    tb_clock_gen clk_gen0 (
        .clk_o (clk),
        .rst_o (rst)
    );

    tb_main_memory mem0 (
        .clk_i       (clk),
        .rst_i       (rst),
        .mem_req_i   (mem_req),
        .mem_ready_o (mem_ready),
        .mem_rsp_o   (mem_rsp),
        .req_count_o (req_count)
    );

    icache_fetch_top dut0 (
        .clk_i       (clk),
        .rst_i       (rst),
        .stall_i     (stall),
        .redirect_i  (redirect),
        .mem_ready_i (mem_ready),
        .mem_rsp_i   (mem_rsp),
        .mem_req_o   (mem_req),
        .fetch_o     (fetch)
    );

    // outputs are recorded mid-cycle, where they have settled
    initial begin
        rsp_seen = 0;
        forever begin
            @(negedge clk);
            if (rst && fetch.valid) fetch_q.push_back(fetch);
            if (rst && mem_req.valid) req_q.push_back(mem_req);
            if (rst && mem_rsp.ready) rsp_seen++;
        end
    end

    // kind 0 counts deliveries, 1 memory requests, 2 memory responses
    function automatic int count_of(input int kind);
        return (kind == 0) ? fetch_q.size() : (kind == 1) ? req_q.size() : rsp_seen;
    endfunction

    task automatic wait_events(input int kind, input int target, input string what);
        int cycles;
        cycles = 0;
        while (count_of(kind) < target && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (count_of(kind) < target) begin
            $display("%s did not happen within %0d cycles", what, WAIT_LIMIT);
            timeouts++;
        end
    endtask

    function automatic fetch_out_t expected_fetch(input logic [31:0] pc);
        return fetch_out_t'{1'b1, pc, pc ^ 32'hA5A5_0000};
    endfunction

    task automatic check_fetch(input fetch_out_t got, input fetch_out_t exp);
        if (got !== exp) begin
            $display("Error: fetch_o pc 0x%08h instr 0x%08h valid %0h, expected 0x%08h 0x%08h %0h",
                     got.pc, got.instr, got.valid, exp.pc, exp.instr, exp.valid);
            value_errors++;
        end
    endtask

    task automatic check_req(input mem_req_t got, input mem_req_t exp);
        if (got !== exp) begin
            $display("Error: mem_req_o addr 0x%08h valid %0h, expected 0x%08h %0h",
                     got.addr, got.valid, exp.addr, exp.valid);
            value_errors++;
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("Error: %s got 0x%0h, expected 0x%0h", name, got, exp);
            value_errors++;
        end
    endtask

    // loads a new pc while stalled, then lets fetch run
    task automatic redirect_to(input logic [31:0] target);
        @(posedge clk);
        redirect <= redirect_t'{1'b1, target};
        @(posedge clk);
        redirect <= '0;
        stall    <= 1'b0;
    endtask

    task automatic take_fetches(input int n, input string what);
        wait_events(0, fetch_q.size() + n, what);
        stall <= 1'b1;  // freezes the pc right after the last delivery
    endtask

    task automatic fetch_at(input logic [31:0] addr);
        redirect_to(addr);
        take_fetches(1, "delivery after a redirect");
        check_fetch(fetch_q[$], expected_fetch(addr));
    endtask

    task automatic test_cold_fetch();
        take_fetches(8, "cold sequential fetch");
        for (int i = 0; i < 8; i++) begin
            check_fetch(fetch_q[i], expected_fetch(32'(4 * i)));
        end
        check_count("req_count_o", req_count, 2);
        check_req(req_q[0], mem_req_t'{1'b1, 32'h0000_0000});
        check_req(req_q[1], mem_req_t'{1'b1, 32'h0000_0010});
    endtask

    task automatic test_warm_hits();
        int first;
        int base;
        first = fetch_q.size();
        base  = req_count;
        redirect_to(32'h0000_0000);
        take_fetches(8, "warm hits");
        for (int i = 0; i < 8; i++) begin
            check_fetch(fetch_q[first + i], expected_fetch(32'(4 * i)));
        end
        check_count("req_count_o", req_count, base);
    endtask

    task automatic test_stall();
        int first;
        int base;
        first = fetch_q.size();
        repeat (6) @(posedge clk);
        check_count("fetch_o.valid count", fetch_q.size() - first, 0);
        stall <= 1'b0;
        take_fetches(1, "delivery after stall release");
        check_fetch(fetch_q[first], expected_fetch(32'h0000_0020));
        // stall covers the whole miss, response cycle included
        redirect_to(32'h0000_0100);
        wait_events(1, req_q.size() + 1, "request for line 0x100");
        stall <= 1'b1;
        wait_events(2, rsp_seen + 1, "response for line 0x100");
        repeat (2) @(posedge clk);
        base = req_count;
        check_count("fetch_o.valid count", fetch_q.size() - first, 1);
        stall <= 1'b0;
        take_fetches(1, "hit on the line filled under stall");
        check_fetch(fetch_q[$], expected_fetch(32'h0000_0100));
        check_count("req_count_o", req_count, base);
    endtask

    task automatic test_redirect_in_miss();
        int first;
        int reqs;
        first = fetch_q.size();
        reqs  = req_q.size();
        redirect_to(32'h0000_0200);
        wait_events(1, reqs + 1, "request for line 0x200");
        redirect <= redirect_t'{1'b1, 32'h0000_0344};  // lands while memory is busy
        @(posedge clk);
        redirect <= '0;
        take_fetches(1, "delivery after a redirect during a miss");
        check_fetch(fetch_q[first], expected_fetch(32'h0000_0344));
        check_req(req_q[reqs], mem_req_t'{1'b1, 32'h0000_0200});
        check_req(req_q[reqs + 1], mem_req_t'{1'b1, 32'h0000_0340});
    endtask

    task automatic test_conflict_eviction();
        int base;
        fetch_at(32'h0000_0800);  // a third tag on index 0 evicts line 0 first
        base = req_count;
        fetch_at(32'h0000_0000);
        fetch_at(32'h0000_0400);
        fetch_at(32'h0000_0000);
        check_count("req_count_o", req_count, base + 3);
    endtask

    initial begin
        int cycles;
        stall        = 1'b0;
        redirect     = '0;
        value_errors = 0;
        timeouts     = 0;
        cycles       = 0;
        while (!rst && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (!rst) begin
            $display("reset was never released");
            timeouts++;
        end
        test_cold_fetch();
        test_warm_hits();
        test_stall();
        test_redirect_in_miss();
        test_conflict_eviction();
        $display("value errors %0d, timeouts %0d", value_errors, timeouts);
        if (value_errors == 0 && timeouts == 0) begin
            $display("Simulation passed");
        end
        else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* compile.f */
icache_pkg.sv
fetch_pc.sv
icache_array.sv
icache_controller.sv
icache_fetch_top.sv
tb_clock_gen.sv
tb_main_memory.sv
tb_icache_fetch.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = tb_icache_fetch
FILELIST  = compile.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Simulation passed"

clean:
	rm -rf $(OBJ_DIR)
